// File: include/tio_consts.svh
`ifndef TIO_CONSTS_SVH
`define TIO_CONSTS_SVH

////////////////////////////////////////////////////////////
// Identification and version
////////////////////////////////////////////////////////////

// ASCII "TFIO"
`define TIO_IDENT 32'h5446_494F
// Date 0, major 0, minor 1, revision 25
`define TIO_VERSION 32'h0000_0119

// Register word address width
`define TIO_WB_AW 12

// Register map, word addresses
`define TIO_ADDR_ID   12'h000
`define TIO_ADDR_VER  12'h001
`define TIO_ADDR_CTRL 12'h002
`define TIO_ADDR_STAT 12'h003

////////////////////////////////////////////////////////////
// Crate UART retiming
////////////////////////////////////////////////////////////

// Sample cycle within a bit period
`define TIO_SAMPLE_POINT 120
// Clock cycles per bit
`define TIO_BAUD_PERIOD 160
// Start, 8 data, stop
`define TIO_UART_BITS 10

`endif

// File: src/tio_pkg.sv
package tio_pkg;

    // Register data word
    typedef logic [31:0] word_t;

    // Control register, bits 3..0
    // Packed struct lists the MSB first
    typedef struct packed {
        // Crate 3.3 V supply on
        logic enable_3v3;
        // SURFs on
        logic enable_crate;
        // Crate bus enable from software
        logic crate_en;
        // Debug port drives the crate bus
        logic hsk_local;
    } hsk_ctrl_t;

    // Status register, bits 3..0
    typedef struct packed {
        // Crate configuration pins
        logic [1:0] conf;
        // OR of software and external enable
        logic crate_en_active;
        // Registered trigger-board control
        logic tctrl_b;
    } hsk_stat_t;

endpackage

// File: src/wb_if.sv
// Classic single-cycle Wishbone, word addressed
interface wb_if #(
    parameter int AW = 12
);
    import tio_pkg::*;

    // Bus cycle and strobe
    logic          cyc;
    logic          stb;
    // Write enable
    logic          we;
    // Word address
    logic [AW-1:0] adr;
    // Write and read data
    word_t         dat_w;
    word_t         dat_r;
    // One-cycle acknowledge from the slave
    logic          ack;

    // Bus master side
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // Register block side
    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: src/uart_retime.sv
`include "tio_consts.svh"

// Rebuilds the slow open-drain crate UART line
// Each bit is sampled once at a fixed point of its period
module uart_retime (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic crate_en_i,
    input  logic rx_i,
    output logic rx_retimed_o
);

    localparam int SAMPLE_POINT = `TIO_SAMPLE_POINT;
    localparam int BAUD_PERIOD  = `TIO_BAUD_PERIOD;
    localparam int UART_BITS    = `TIO_UART_BITS;
    localparam int CNT_W        = $clog2(BAUD_PERIOD);
    localparam int BIT_W        = $clog2(UART_BITS);

    // Two-flop synchronizer
    logic             rx_meta;
    logic             rx_sync;
    // Frame in progress
    logic             busy;
    // Cycle within the current bit
    logic [CNT_W-1:0] baud_cnt;
    // Bit within the frame
    logic [BIT_W-1:0] bit_cnt;
    // Sample strobe
    logic             sample;

    assign sample = busy && (baud_cnt == CNT_W'(SAMPLE_POINT));

    ////////////////////////////////////////////////////////////
    // Synchronizer, idles high
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bit timing and output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy         <= 1'b0;
            baud_cnt     <= '0;
            bit_cnt      <= '0;
            rx_retimed_o <= 1'b1;
        end else if (!crate_en_i) begin
            // Crate off, line parked high
            busy         <= 1'b0;
            baud_cnt     <= '0;
            bit_cnt      <= '0;
            rx_retimed_o <= 1'b1;
        end else if (!busy) begin
            // Start bit seen, detect cycle counts as cycle 0
            if (!rx_sync) begin
                busy     <= 1'b1;
                baud_cnt <= CNT_W'(1);
            end
        end else begin
            if (baud_cnt == CNT_W'(BAUD_PERIOD - 1)) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            if (sample) begin
                rx_retimed_o <= rx_sync;
                // Stop bit taken, wait for next start
                if (bit_cnt == BIT_W'(UART_BITS - 1)) begin
                    busy    <= 1'b0;
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/uart_router.sv
// Housekeeping UART routing matrix
// All paths combinational, all idle high
module uart_router (
    input  tio_pkg::hsk_ctrl_t hsk_ctrl_i,
    input  logic               hsk_crate_en_i,
    input  logic               dbg_rx_i,
    input  logic               bm_tx_i,
    input  logic               trx_i,
    input  logic               tctrl_b_i,
    input  logic               from_surf_i,
    output logic               dbg_tx_o,
    output logic               bm_rx_o,
    output logic               f_ttx_o,
    output logic               to_surf_o,
    output logic               crate_en_o
);

    // Merged line toward the crate
    logic to_crate;
    // Trigger-board line, valid only with tctrl_b low
    logic from_turf;

    // Either software or the external pin opens the crate bus
    assign crate_en_o = hsk_ctrl_i.crate_en | hsk_crate_en_i;

    ////////////////////////////////////////////////////////////
    // Crate side
    ////////////////////////////////////////////////////////////

    assign from_turf = tctrl_b_i ? 1'b1 : trx_i;

    // Local mode hands the crate to the debug port
    assign to_crate = hsk_ctrl_i.hsk_local ? dbg_rx_i : from_turf;

    // Nothing reaches the SURFs with the crate off
    assign to_surf_o = crate_en_o ? to_crate : 1'b1;

    ////////////////////////////////////////////////////////////
    // Debug, board manager and trigger board
    ////////////////////////////////////////////////////////////

    // Debug port sees the crate in local mode, board manager otherwise
    assign dbg_tx_o = hsk_ctrl_i.hsk_local ? from_surf_i : bm_tx_i;

    // Board manager detached in local mode
    assign bm_rx_o = hsk_ctrl_i.hsk_local ? 1'b1 : dbg_rx_i;

    // Trigger board detached in local mode
    assign f_ttx_o = hsk_ctrl_i.hsk_local ? 1'b1 : from_surf_i;

endmodule

// File: src/tio_id_regs.sv
`include "tio_consts.svh"

// Wishbone register block
// Word 0 ID, word 1 version, word 2 control, word 3 status
module tio_id_regs (
    input  logic               clk_i,
    input  logic               rst_n_i,
    wb_if.slave                wb,
    input  logic               crate_en_i,
    input  logic               tctrl_b_i,
    input  logic [1:0]         conf_i,
    output tio_pkg::hsk_ctrl_t hsk_ctrl_o
);

    import tio_pkg::*;

    // New request, ack gates the second cycle
    logic       req;
    // Registered status inputs
    logic       tctrl_b_q;
    logic [1:0] conf_q;
    // Status word as seen now
    hsk_stat_t  stat;
    // Read mux output
    word_t      rd_data;

    assign req = wb.cyc && wb.stb && !wb.ack;

    assign stat.conf            = conf_q;
    assign stat.crate_en_active = crate_en_i;
    assign stat.tctrl_b         = tctrl_b_q;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (wb.adr)
            `TIO_ADDR_ID:   rd_data = `TIO_IDENT;
            `TIO_ADDR_VER:  rd_data = `TIO_VERSION;
            `TIO_ADDR_CTRL: rd_data = word_t'(hsk_ctrl_o);
            `TIO_ADDR_STAT: rd_data = word_t'(stat);
            // Unused space reads zero
            default:        rd_data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Handshake and control register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.ack     <= 1'b0;
            hsk_ctrl_o <= '0;
        end else begin
            // One-cycle ack per request
            wb.ack <= req;
            // Only control is writable, others ack and drop
            if (req && wb.we && (wb.adr == `TIO_ADDR_CTRL)) begin
                hsk_ctrl_o <= hsk_ctrl_t'(wb.dat_w[3:0]);
            end
        end
    end

    // Read data valid with ack
    always_ff @(posedge clk_i) begin
        if (req) begin
            wb.dat_r <= rd_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Status input registers
    ////////////////////////////////////////////////////////////

    // Pins are asynchronous to init_clk
    always_ff @(posedge clk_i) begin
        tctrl_b_q <= tctrl_b_i;
        conf_q    <= conf_i;
    end

endmodule

// File: src/tio_hsk_top.sv
`include "tio_consts.svh"

// Housekeeping serial routing of the crate interface
module tio_hsk_top (
    input  logic                  init_clk,
    input  logic                  rst_n_i,
    // Wishbone slave port
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`TIO_WB_AW-1:0] wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack_o,
    // Debug port
    input  logic                  dbg_rx_i,
    output logic                  dbg_tx_o,
    // Board manager
    input  logic                  bm_tx_i,
    output logic                  bm_rx_o,
    // Trigger board
    input  logic                  trx_i,
    output logic                  f_ttx_o,
    input  logic                  tctrl_b_i,
    // Crate bus, SURF side
    input  logic                  surf_tx_i,
    output logic                  surf_rx_o,
    // Crate and supplies
    input  logic                  hsk_crate_en_i,
    input  logic [1:0]            conf_i,
    output logic                  enable_crate_o,
    output logic                  enable_3v3_o
);

    import tio_pkg::*;

    // Control bits from the register block
    hsk_ctrl_t hsk_ctrl;
    // Effective crate enable
    logic      crate_en;
    // Retimed crate line
    logic      uart_from_surf;

    wb_if #(.AW(`TIO_WB_AW)) wb_bus ();

    ////////////////////////////////////////////////////////////
    // Bus master side from the pins
    ////////////////////////////////////////////////////////////
    assign wb_bus.cyc   = wb_cyc_i;
    assign wb_bus.stb   = wb_stb_i;
    assign wb_bus.we    = wb_we_i;
    assign wb_bus.adr   = wb_adr_i;
    assign wb_bus.dat_w = wb_dat_i;
    assign wb_dat_o     = wb_bus.dat_r;
    assign wb_ack_o     = wb_bus.ack;

    // Supply and SURF enables straight from control
    assign enable_crate_o = hsk_ctrl.enable_crate;
    assign enable_3v3_o   = hsk_ctrl.enable_3v3;

    tio_id_regs u_regs (
        .clk_i      (init_clk),
        .rst_n_i    (rst_n_i),
        .wb         (wb_bus.slave),
        .crate_en_i (crate_en),
        .tctrl_b_i  (tctrl_b_i),
        .conf_i     (conf_i),
        .hsk_ctrl_o (hsk_ctrl)
    );

    uart_router u_router (
        .hsk_ctrl_i     (hsk_ctrl),
        .hsk_crate_en_i (hsk_crate_en_i),
        .dbg_rx_i       (dbg_rx_i),
        .bm_tx_i        (bm_tx_i),
        .trx_i          (trx_i),
        .tctrl_b_i      (tctrl_b_i),
        .from_surf_i    (uart_from_surf),
        .dbg_tx_o       (dbg_tx_o),
        .bm_rx_o        (bm_rx_o),
        .f_ttx_o        (f_ttx_o),
        .to_surf_o      (surf_rx_o),
        .crate_en_o     (crate_en)
    );

    uart_retime u_retime (
        .clk_i        (init_clk),
        .rst_n_i      (rst_n_i),
        .crate_en_i   (crate_en),
        .rx_i         (surf_tx_i),
        .rx_retimed_o (uart_from_surf)
    );

endmodule

// File: verif/tb_tio_hsk.sv
`include "tio_consts.svh"

module tb_tio_hsk;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int BAUD       = `TIO_BAUD_PERIOD;
    localparam int SAMPLE     = `TIO_SAMPLE_POINT;
    localparam int BITS       = `TIO_UART_BITS;
    localparam int NUM_REG    = 16;
    localparam int NUM_ROUTE  = 40;
    localparam int NUM_FRAMES = 3;
    localparam int IDLE       = 8;
    // Reset, register and routing loops plus three rounds of frames and a margin
    localparam int TEST_CYCLES = 20 + NUM_REG * 16 + NUM_ROUTE * 6
                               + 3 * NUM_FRAMES * (BITS * BAUD + IDLE) + 500;

    logic                  init_clk;
    logic                  rst_n_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    logic [`TIO_WB_AW-1:0] wb_adr_i;
    logic [31:0]           wb_dat_i;
    logic [31:0]           wb_dat_o;
    logic                  wb_ack_o;
    logic                  dbg_rx_i;
    logic                  dbg_tx_o;
    logic                  bm_tx_i;
    logic                  bm_rx_o;
    logic                  trx_i;
    logic                  f_ttx_o;
    logic                  tctrl_b_i;
    logic                  surf_tx_i;
    logic                  surf_rx_o;
    logic                  hsk_crate_en_i;
    logic [1:0]            conf_i;
    logic                  enable_crate_o;
    logic                  enable_3v3_o;

    // Expected control word with hsk_local in bit 0 and enable_3v3 in bit 3
    logic [3:0]  ctrl_model;
    logic [31:0] lfsr;

    tio_hsk_top DUT (.*);

    initial begin
        init_clk = 1'b0;
        forever #(CLK_PERIOD / 2) init_clk = ~init_clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit with the newest bit in the LSB
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge init_clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "value check failed");
        end
    endtask

    // Routing rules where from_surf is the expected retimed crate line
    task automatic check_routing(input logic from_surf);
        logic crate_on;
        logic crate_in;
        logic exp_dbg;
        logic exp_bm;
        logic exp_ttx;
        crate_on = ctrl_model[1] | hsk_crate_en_i;
        if (ctrl_model[0]) begin
            crate_in = dbg_rx_i;
            exp_dbg  = from_surf;
            exp_bm   = 1'b1;
            exp_ttx  = 1'b1;
        end else begin
            crate_in = tctrl_b_i ? 1'b1 : trx_i;
            exp_dbg  = bm_tx_i;
            exp_bm   = dbg_rx_i;
            exp_ttx  = from_surf;
        end
        check_value("dbg_tx_o", dbg_tx_o, exp_dbg);
        check_value("bm_rx_o", bm_rx_o, exp_bm);
        check_value("f_ttx_o", f_ttx_o, exp_ttx);
        check_value("surf_rx_o", surf_rx_o, crate_on ? crate_in : 1'b1);
    endtask

    // Single Wishbone access with ack exactly one cycle after the request
    task automatic wb_access(input logic we, input logic [`TIO_WB_AW-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        check_value("wb_ack_o", wb_ack_o, 1'b0);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        next_cycle();
        check_value("wb_ack_o", wb_ack_o, 1'b1);
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        next_cycle();
        check_value("wb_ack_o", wb_ack_o, 1'b0);
    endtask

    task automatic read_expect(input logic [`TIO_WB_AW-1:0] adr, input logic [31:0] exp);
        logic [31:0] rd;
        wb_access(1'b0, adr, 32'h0, rd);
        check_value("wb_dat_o", rd, exp);
    endtask

    task automatic write_word(input logic [`TIO_WB_AW-1:0] adr, input logic [31:0] data);
        logic [31:0] rd;
        wb_access(1'b1, adr, data, rd);
        if (adr == `TIO_ADDR_CTRL) begin
            ctrl_model = data[3:0];
        end
        check_value("enable_crate_o", enable_crate_o, ctrl_model[2]);
        check_value("enable_3v3_o", enable_3v3_o, ctrl_model[3]);
    endtask

    // One UART frame on surf_tx_i sent LSB first
    task automatic send_frame(input logic crate_on);
        logic [31:0] r;
        logic [9:0]  frame;
        int          k;
        int          c;
        r = rand_bits(8);
        frame = {1'b1, r[7:0], 1'b0};
        for (k = 0; k < BITS; k++) begin
            surf_tx_i = frame[k];
            for (c = 1; c <= BAUD; c++) begin
                if (!crate_on) begin
                    r = rand_bits(2);
                    dbg_rx_i = r[0];
                    trx_i    = r[1];
                end
                next_cycle();
                if (!crate_on) begin
                    // Nothing gets through a closed crate
                    check_routing(1'b1);
                end else if (c == SAMPLE + 4) begin
                    check_routing(frame[k]);
                end
            end
        end
        dbg_rx_i = 1'b1;
        trx_i    = 1'b1;
        repeat (IDLE) next_cycle();
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence completed");
        $display("Errors found");
        $fatal(1, "timeout");
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r;
        int          n;
        int          m;
        lfsr           = 32'h2dd0_6525;
        ctrl_model     = 4'h0;
        rst_n_i        = 1'b0;
        wb_cyc_i       = 1'b0;
        wb_stb_i       = 1'b0;
        wb_we_i        = 1'b0;
        wb_adr_i       = '0;
        wb_dat_i       = '0;
        dbg_rx_i       = 1'b1;
        bm_tx_i        = 1'b1;
        trx_i          = 1'b1;
        tctrl_b_i      = 1'b0;
        surf_tx_i      = 1'b1;
        hsk_crate_en_i = 1'b0;
        conf_i         = 2'b00;
        repeat (10) @(posedge init_clk);
        #2;
        rst_n_i = 1'b1;
        next_cycle();

        // After reset
        check_value("enable_crate_o", enable_crate_o, 1'b0);
        check_value("enable_3v3_o", enable_3v3_o, 1'b0);
        check_value("wb_ack_o", wb_ack_o, 1'b0);
        check_routing(1'b1);
        read_expect(`TIO_ADDR_CTRL, 32'h0);

        // Register block
        read_expect(`TIO_ADDR_ID, `TIO_IDENT);
        read_expect(`TIO_ADDR_VER, `TIO_VERSION);
        read_expect(12'h0a5, 32'h0);
        for (n = 0; n < NUM_REG; n++) begin
            write_word(`TIO_ADDR_CTRL, rand_bits(32));
            read_expect(`TIO_ADDR_CTRL, {28'h0, ctrl_model});
            write_word(`TIO_ADDR_ID, rand_bits(32));
            read_expect(`TIO_ADDR_ID, `TIO_IDENT);
            r = rand_bits(4);
            conf_i         = r[1:0];
            tctrl_b_i      = r[2];
            hsk_crate_en_i = r[3];
            next_cycle();
            read_expect(`TIO_ADDR_STAT,
                        {28'h0, conf_i, ctrl_model[1] | hsk_crate_en_i, tctrl_b_i});
        end

        // Routing matrix with the crate line idle
        for (n = 0; n < NUM_ROUTE; n++) begin
            write_word(`TIO_ADDR_CTRL, rand_bits(4));
            r = rand_bits(5);
            dbg_rx_i       = r[0];
            bm_tx_i        = r[1];
            trx_i          = r[2];
            tctrl_b_i      = r[3];
            hsk_crate_en_i = r[4];
            next_cycle();
            check_routing(1'b1);
        end

        // Retiming toward the trigger board and then toward the debug port
        dbg_rx_i       = 1'b1;
        trx_i          = 1'b1;
        hsk_crate_en_i = 1'b0;
        // Trigger-board line open toward the crate input
        tctrl_b_i      = 1'b0;
        for (m = 0; m < 2; m++) begin
            r = rand_bits(2);
            write_word(`TIO_ADDR_CTRL, {28'h0, r[1:0], 1'b1, m[0]});
            for (n = 0; n < NUM_FRAMES; n++) begin
                send_frame(1'b1);
            end
        end

        // Crate disabled
        r = rand_bits(2);
        write_word(`TIO_ADDR_CTRL, {28'h0, r[1:0], 2'b00});
        for (n = 0; n < NUM_FRAMES; n++) begin
            send_frame(1'b0);
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: tio_hsk.f
+incdir+include
src/tio_pkg.sv
src/wb_if.sv
src/uart_retime.sv
src/uart_router.sv
src/tio_id_regs.sv
src/tio_hsk_top.sv
verif/tb_tio_hsk.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f tio_hsk.f --top-module tb_tio_hsk -o sim_tio_hsk

out=$(./obj_dir/sim_tio_hsk 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'No errors'; then
    exit 0
else
    exit 1
fi
